// ==== src/ahb_pkg.sv ====
// shared AHB-Lite types for the memory slave
// imported by the burst tracker and the slave controller
`default_nettype none

package ahb_pkg;

    // bus is one word wide
    localparam int hdata_w = 32;

    // transfer type, address phase
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_t;

    // burst encodings, 8 and 16 beat kinds are rejected by the slave
    typedef enum logic [2:0] {
        SINGLE = 3'b000,
        INCR   = 3'b001,
        WRAP4  = 3'b010,
        INCR4  = 3'b011,
        WRAP8  = 3'b100,
        INCR8  = 3'b101,
        WRAP16 = 3'b110,
        INCR16 = 3'b111
    } hburst_t;

    // transfer size, anything above WORD is an error here
    typedef enum logic [2:0] {
        BYTE     = 3'b000,
        HALF     = 3'b001,
        WORD     = 3'b010,
        DWORD    = 3'b011,
        QWORD    = 3'b100,
        OWORD    = 3'b101,
        SIZE512  = 3'b110,
        SIZE1024 = 3'b111
    } hsize_t;

    // address phase signals from the master
    typedef struct packed {
        logic [31:0] haddr;
        logic        hwrite;
        hsize_t      hsize;
        hburst_t     hburst;
        htrans_t     htrans;
    } ahb_req_t;

    // slave response
    typedef struct packed {
        logic [hdata_w-1:0] hrdata;
        logic               hreadyout;
        logic               hresp;
    } ahb_rsp_t;

    // registered data phase state of the controller
    typedef struct packed {
        logic        valid;
        logic        write;
        logic        error;
        logic [31:0] word_idx;
        logic [3:0]  strb;
    } dphase_t;

endpackage

`default_nettype wire

// ==== src/ahb_burst_tracker.sv ====
// burst address tracker, follows a burst from its NONSEQ beat on
// computes the expected SEQ address and flags beats that break the sequence
`timescale 1ns/100ps
`default_nettype none

module ahb_burst_tracker (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic              hready,
    output logic              seq_err
);

    import ahb_pkg::*;

    // open burst state
    logic        burst_open;
    hburst_t     burst_type;
    hsize_t      burst_size;
    logic [31:0] expect_addr;
    // beats still to come in a four-beat burst
    logic [1:0]  beats_left;

    logic        accept_nonseq;
    logic        accept_seq;
    logic        accept_idle;
    logic        start_burst;
    logic        fixed_len;

    // address of the beat after addr
    function automatic logic [31:0] next_beat(
        input logic [31:0] addr,
        input hsize_t      size,
        input hburst_t     burst
    );
        logic [31:0] step;
        logic [31:0] wrap_mask;
        step = 32'd1 << size;
        // wrap boundary is four beats of the transfer size
        wrap_mask = (step << 2) - 32'd1;
        if (burst == WRAP4) begin
            next_beat = (addr & ~wrap_mask) | ((addr + step) & wrap_mask);
        end else begin
            next_beat = addr + step;
        end
    endfunction

    // beats taken at this edge
    assign accept_nonseq = hready && (req.htrans == NONSEQ);
    assign accept_seq    = hready && (req.htrans == SEQ);
    assign accept_idle   = hready && (req.htrans == IDLE);

    // only these three kinds open a burst
    assign start_burst = (req.hburst == INCR) || (req.hburst == INCR4) ||
                         (req.hburst == WRAP4);

    // incr has no fixed length
    assign fixed_len = (burst_type == INCR4) || (burst_type == WRAP4);

    // judged in the address phase of the SEQ beat itself
    always_comb begin
        seq_err = 1'b0;
        if (req.htrans == SEQ) begin
            seq_err = !burst_open ||
                      (req.haddr != expect_addr) ||
                      (req.hburst != burst_type) ||
                      (req.hsize != burst_size);
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            burst_open  <= 1'b0;
            burst_type  <= SINGLE;
            burst_size  <= BYTE;
            expect_addr <= '0;
            beats_left  <= '0;
        end else if (accept_nonseq) begin
            // new transfer, SINGLE leaves nothing open
            burst_open  <= start_burst;
            burst_type  <= req.hburst;
            burst_size  <= req.hsize;
            expect_addr <= next_beat(req.haddr, req.hsize, req.hburst);
            // three more after the first beat
            beats_left  <= 2'd3;
        end else if (accept_seq) begin
            if (seq_err) begin
                // broken sequence, master has to restart with NONSEQ
                burst_open <= 1'b0;
            end else begin
                expect_addr <= next_beat(expect_addr, burst_size, burst_type);
                if (fixed_len) begin
                    beats_left <= beats_left - 2'd1;
                    // last beat of incr4 or wrap4
                    if (beats_left == 2'd1) begin
                        burst_open <= 1'b0;
                    end
                end
            end
        end else if (accept_idle) begin
            // idle ends an incr burst or cuts a fixed one short
            burst_open <= 1'b0;
        end
        // BUSY and stalled cycles keep everything
    end

endmodule

`default_nettype wire

// ==== src/ahb_slave_ctrl.sv ====
// AHB-Lite slave control for the on-chip memory
// checks each accepted transfer, drives the memory ports and the response
`timescale 1ns/100ps
`default_nettype none

module ahb_slave_ctrl #(
    parameter int unsigned mem_words = 1024
) (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic              hready,
    input  logic [31:0]       hwdata,
    input  logic              seq_err,
    output logic              mem_re,
    output logic [31:0]       mem_raddr,
    input  logic [31:0]       mem_rdata,
    output logic              mem_we,
    output logic [3:0]        mem_wstrb,
    output logic [31:0]       mem_waddr,
    output logic [31:0]       mem_wdata,
    output ahb_pkg::ahb_rsp_t rsp
);

    import ahb_pkg::*;

    // memory size in bytes, one bit wider than haddr
    localparam logic [32:0] mem_bytes = 33'(mem_words) << 2;

    logic        accept;
    logic        range_err;
    logic        size_err;
    logic        align_err;
    logic        burst_err;
    logic        xfer_err;
    logic [3:0]  strb;

    // data phase of the transfer accepted last
    dphase_t     dp;
    // second cycle of the error response
    logic        err_second;

    // write committed at the same edge as a read of that word
    logic        fwd_hit;
    logic [3:0]  fwd_strb;
    logic [31:0] fwd_data;

    // address phase taken at this edge
    assign accept = hready && ((req.htrans == NONSEQ) || (req.htrans == SEQ));

    assign range_err = {1'b0, req.haddr} >= mem_bytes;
    assign size_err  = req.hsize > WORD;
    // 8 and 16 beat bursts not supported
    assign burst_err = req.hburst inside {WRAP8, INCR8, WRAP16, INCR16};
    assign xfer_err  = range_err || size_err || align_err || burst_err || seq_err;

    // byte lanes and alignment from size and low address bits
    always_comb begin
        align_err = 1'b0;
        strb      = 4'b0000;
        case (req.hsize)
            BYTE: begin
                strb = 4'b0001 << req.haddr[1:0];
            end
            HALF: begin
                strb      = 4'b0011 << {req.haddr[1], 1'b0};
                align_err = req.haddr[0];
            end
            WORD: begin
                strb      = 4'b1111;
                align_err = |req.haddr[1:0];
            end
            default: begin
                // wider sizes are caught by size_err
                strb = 4'b0000;
            end
        endcase
    end

    // read goes out in the address phase, data is back next cycle
    assign mem_re    = accept && !xfer_err && !req.hwrite;
    assign mem_raddr = {2'b00, req.haddr[31:2]};

    // data phase state moves only when the bus is ready
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dp <= '0;
        end else if (hready) begin
            dp.valid    <= accept;
            dp.write    <= req.hwrite;
            dp.error    <= xfer_err;
            dp.word_idx <= {2'b00, req.haddr[31:2]};
            dp.strb     <= strb;
        end
    end

    // first error cycle stalls, second one completes
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            err_second <= 1'b0;
        end else if (hready) begin
            err_second <= 1'b0;
        end else if (dp.valid && dp.error) begin
            err_second <= 1'b1;
        end
    end

    // write commits at the end of the data phase, hwdata valid then
    assign mem_we    = hready && dp.valid && dp.write && !dp.error;
    assign mem_waddr = dp.word_idx;
    assign mem_wstrb = dp.strb;
    assign mem_wdata = hwdata;

    // memory read sees the old word when both hit one edge
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fwd_hit <= 1'b0;
        end else begin
            fwd_hit <= mem_re && mem_we && (mem_raddr == mem_waddr);
        end
    end

    always_ff @(posedge clk) begin
        fwd_strb <= mem_wstrb;
        fwd_data <= mem_wdata;
    end

    // response, read data with written bytes merged in
    always_comb begin
        rsp = '0;
        for (int b = 0; b < 4; b++) begin
            if (fwd_hit && fwd_strb[b]) begin
                rsp.hrdata[8*b +: 8] = fwd_data[8*b +: 8];
            end else begin
                rsp.hrdata[8*b +: 8] = mem_rdata[8*b +: 8];
            end
        end
        // low only in the first cycle of an error
        rsp.hreadyout = !(dp.valid && dp.error && !err_second);
        rsp.hresp     = dp.valid && dp.error;
    end

endmodule

`default_nettype wire

// ==== src/sram_bank.sv ====
// word-wide synchronous memory behind the AHB slave
// one cycle read latency, byte lane writes take effect at the edge
`timescale 1ns/100ps
`default_nettype none

module sram_bank #(
    parameter int unsigned mem_words = 1024
) (
    input  logic        clk,
    input  logic        re,
    input  logic [31:0] raddr,
    output logic [31:0] rdata,
    input  logic        we,
    input  logic [3:0]  wstrb,
    input  logic [31:0] waddr,
    input  logic [31:0] wdata
);

    // word index bits actually used
    localparam int aw = $clog2(mem_words);

    logic [31:0] mem [mem_words];

    // registered read, old contents on a same-edge write
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[raddr[aw-1:0]];
        end
    end

    // per-byte write
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (wstrb[b]) begin
                    mem[waddr[aw-1:0]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/ahb_mem_slave.sv ====
// AHB-Lite memory slave, top level
// burst tracker, slave controller and memory bank on one bus port
`timescale 1ns/100ps
`default_nettype none

module ahb_mem_slave #(
    parameter int unsigned mem_words = 1024
) (
    input  logic              clk,
    input  logic              rstn,
    input  ahb_pkg::ahb_req_t req,
    input  logic              hready,
    input  logic [31:0]       hwdata,
    output ahb_pkg::ahb_rsp_t rsp
);

    // tracker verdict on the current SEQ beat
    logic        seq_err;

    // memory read port, address phase in and data phase out
    logic        mem_re;
    logic [31:0] mem_raddr;
    logic [31:0] mem_rdata;

    // memory write port, data phase
    logic        mem_we;
    logic [3:0]  mem_wstrb;
    logic [31:0] mem_waddr;
    logic [31:0] mem_wdata;

    ahb_burst_tracker i_ahb_burst_tracker (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .hready  (hready),
        .seq_err (seq_err)
    );

    ahb_slave_ctrl #(
        .mem_words (mem_words)
    ) i_ahb_slave_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .hready    (hready),
        .hwdata    (hwdata),
        .seq_err   (seq_err),
        .mem_re    (mem_re),
        .mem_raddr (mem_raddr),
        .mem_rdata (mem_rdata),
        .mem_we    (mem_we),
        .mem_wstrb (mem_wstrb),
        .mem_waddr (mem_waddr),
        .mem_wdata (mem_wdata),
        .rsp       (rsp)
    );

    // memory has no reset
    sram_bank #(
        .mem_words (mem_words)
    ) i_sram_bank (
        .clk   (clk),
        .re    (mem_re),
        .raddr (mem_raddr),
        .rdata (mem_rdata),
        .we    (mem_we),
        .wstrb (mem_wstrb),
        .waddr (mem_waddr),
        .wdata (mem_wdata)
    );

endmodule

`default_nettype wire

// ==== tb/tb_ahb_mem_slave.sv ====
// testbench for the AHB-Lite memory slave
// directed tests run pipelined beat lists and check against a reference memory
`timescale 1ns/100ps
`default_nettype none

module tb_ahb_mem_slave;

    import ahb_pkg::*;

    localparam ahb_req_t idle_req = '{haddr: '0, hwrite: 1'b0, hsize: WORD,
                                      hburst: SINGLE, htrans: IDLE};
    localparam int max_beats = 16;

    logic        clk;
    logic        rstn;
    ahb_req_t    req;
    logic        hready;
    logic [31:0] hwdata;
    ahb_rsp_t    rsp;
    // forces the bus ready low for back-pressure
    logic        stall;
    logic [31:0] lfsr_state = 32'd66510;
    logic [31:0] ref_mem [1024];

    // beat list and what came back for each beat
    ahb_req_t    x_req        [max_beats];
    logic [31:0] x_wdata      [max_beats];
    logic        x_exp_err    [max_beats];
    logic [31:0] x_rdata      [max_beats];
    logic        x_resp       [max_beats];
    int          x_stall      [max_beats];
    logic        x_stall_resp [max_beats];
    int          n_x;

    // single slave, bus ready follows the slave
    assign hready = rsp.hreadyout && !stall;

    ahb_mem_slave #(
        .mem_words (1024)
    ) i_ahb_mem_slave (
        .clk    (clk),
        .rstn   (rstn),
        .req    (req),
        .hready (hready),
        .hwdata (hwdata),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        rand_bits = v;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // byte lanes from size and low address bits, as on the bus
    task automatic ref_write(input logic [31:0] addr, input hsize_t size,
                             input logic [31:0] data);
        logic [3:0] lanes;
        case (size)
            BYTE:    lanes = 4'b0001 << addr[1:0];
            HALF:    lanes = addr[1] ? 4'b1100 : 4'b0011;
            default: lanes = 4'b1111;
        endcase
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) begin
                ref_mem[addr[11:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic add_beat(input logic [31:0] addr, input logic write, input hsize_t size,
                            input hburst_t burst, input htrans_t trans,
                            input logic [31:0] data, input logic exp_err);
        x_req[n_x] = '{haddr: addr, hwrite: write, hsize: size, hburst: burst, htrans: trans};
        x_wdata[n_x]   = data;
        x_exp_err[n_x] = exp_err;
        n_x++;
    endtask

    // address and data phases overlap, one beat offered per cycle
    task automatic run_beats();
        int       i;
        int       dp_i;
        int       cycles;
        logic     rdy;
        ahb_rsp_t r;
        i      = 0;
        dp_i   = -1;
        cycles = 0;
        for (int k = 0; k < n_x; k++) begin
            x_stall[k]      = 0;
            x_stall_resp[k] = 1'b0;
        end
        while (i < n_x || dp_i >= 0) begin
            req <= (i < n_x) ? x_req[i] : idle_req;
            if (dp_i >= 0) begin
                hwdata <= x_wdata[dp_i];
            end
            // sample mid-cycle, the values the next edge sees
            @(negedge clk);
            rdy = hready;
            r   = rsp;
            @(posedge clk);
            cycles++;
            if (cycles > 200) begin
                stop_with_failure("bus transfer did not finish within 200 cycles");
            end
            if (!rdy) begin
                // wait state, address stays put
                if (dp_i >= 0) begin
                    x_stall[dp_i]++;
                    x_stall_resp[dp_i] = r.hresp;
                end
            end else begin
                if (dp_i >= 0) begin
                    x_rdata[dp_i] = r.hrdata;
                    x_resp[dp_i]  = r.hresp;
                end
                dp_i = -1;
                if (i < n_x) begin
                    // BUSY and IDLE have no data phase
                    if (x_req[i].htrans inside {NONSEQ, SEQ}) begin
                        dp_i = i;
                    end
                    i++;
                end
            end
        end
        n_x = 0;
    endtask

    // walk the list in bus order so reads see earlier writes
    task automatic check_beats(input int count);
        for (int i = 0; i < count; i++) begin
            if (x_req[i].htrans inside {NONSEQ, SEQ}) begin
                if (x_exp_err[i]) begin
                    // two cycle error, wait state first
                    check_value("wait states", x_stall[i], 1);
                    check_value("hresp first cycle", x_stall_resp[i], 1'b1);
                    check_value("hresp", x_resp[i], 1'b1);
                end else begin
                    check_value("wait states", x_stall[i], 0);
                    check_value("hresp", x_resp[i], 1'b0);
                    if (x_req[i].hwrite) begin
                        ref_write(x_req[i].haddr, x_req[i].hsize, x_wdata[i]);
                    end else begin
                        check_value($sformatf("hrdata @%h", x_req[i].haddr),
                                    x_rdata[i], ref_mem[x_req[i].haddr[11:2]]);
                    end
                end
            end
        end
    endtask

    task automatic run_and_check();
        int count;
        count = n_x;
        run_beats();
        check_beats(count);
    endtask

    // first 64 words get a known pattern
    task automatic fill_memory();
        logic [31:0] a;
        for (int blk = 0; blk < 8; blk++) begin
            for (int w = 0; w < 8; w++) begin
                a = 32'(blk * 32 + w * 4);
                add_beat(a, 1'b1, WORD, SINGLE, NONSEQ, a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_0000,
                         1'b0);
            end
            run_and_check();
        end
    endtask

    task automatic single_transfers();
        for (int off = 0; off < 4; off++) begin
            add_beat(32'h40 + off, 1'b1, BYTE, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        end
        add_beat(32'h44, 1'b1, HALF, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h46, 1'b1, HALF, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h48, 1'b1, WORD, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        // lone byte, other lanes keep the fill
        add_beat(32'h4d, 1'b1, BYTE, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        for (int w = 0; w < 4; w++) begin
            add_beat(32'h40 + 4 * w, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        end
        run_and_check();
    endtask

    task automatic incr_bursts();
        for (int w = 0; w < 4; w++) begin
            add_beat(32'h80 + 4 * w, 1'b1, WORD, INCR4, w == 0 ? NONSEQ : SEQ, rand_bits(32), 1'b0);
        end
        for (int w = 0; w < 4; w++) begin
            add_beat(32'h80 + 4 * w, 1'b0, WORD, INCR4, w == 0 ? NONSEQ : SEQ, '0, 1'b0);
        end
        run_and_check();
        // incr with a BUSY cycle before the third beat
        add_beat(32'ha0, 1'b1, WORD, INCR, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'ha4, 1'b1, WORD, INCR, SEQ, rand_bits(32), 1'b0);
        add_beat(32'ha8, 1'b1, WORD, INCR, BUSY, '0, 1'b0);
        add_beat(32'ha8, 1'b1, WORD, INCR, SEQ, rand_bits(32), 1'b0);
        add_beat(32'hac, 1'b1, WORD, INCR, SEQ, rand_bits(32), 1'b0);
        for (int w = 0; w < 4; w++) begin
            add_beat(32'ha0 + 4 * w, 1'b0, WORD, INCR, w == 0 ? NONSEQ : SEQ, '0, 1'b0);
        end
        run_and_check();
    endtask

    task automatic wrap4_burst();
        logic [31:0] order [4];
        order = '{32'hc8, 32'hcc, 32'hc0, 32'hc4};
        for (int w = 0; w < 4; w++) begin
            add_beat(order[w], 1'b1, WORD, WRAP4, w == 0 ? NONSEQ : SEQ, rand_bits(32), 1'b0);
        end
        for (int w = 0; w < 4; w++) begin
            add_beat(order[w], 1'b0, WORD, WRAP4, w == 0 ? NONSEQ : SEQ, '0, 1'b0);
        end
        // words just outside the wrap block
        add_beat(32'hbc, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'hd0, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
    endtask

    task automatic read_after_write();
        add_beat(32'h60, 1'b1, WORD, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h60, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'h61, 1'b1, BYTE, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h60, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'h66, 1'b1, HALF, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h64, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
    endtask

    task automatic error_responses();
        // 0x1010 would alias word 0x10 if it got through
        add_beat(32'h1010, 1'b1, WORD, SINGLE, NONSEQ, rand_bits(32), 1'b1);
        add_beat(32'h10, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'h71, 1'b1, WORD, SINGLE, NONSEQ, rand_bits(32), 1'b1);
        add_beat(32'h70, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'h78, 1'b1, DWORD, SINGLE, NONSEQ, rand_bits(32), 1'b1);
        add_beat(32'h78, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
        // skipped beat inside an incr4 burst
        add_beat(32'h20, 1'b1, WORD, INCR4, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h28, 1'b1, WORD, INCR4, SEQ, rand_bits(32), 1'b1);
        add_beat(32'h24, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        add_beat(32'h28, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
        // incr4 runs out, then a SEQ at the very address that would follow
        for (int w = 0; w < 4; w++) begin
            add_beat(32'h30 + 4 * w, 1'b0, WORD, INCR4, w == 0 ? NONSEQ : SEQ, '0, 1'b0);
        end
        add_beat(32'h40, 1'b1, WORD, INCR4, SEQ, rand_bits(32), 1'b1);
        add_beat(32'h40, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
    endtask

    task automatic back_pressure();
        // write sits on the bus with ready held low, then is dropped
        req   <= '{haddr: 32'h90, hwrite: 1'b1, hsize: WORD, hburst: SINGLE, htrans: NONSEQ};
        stall <= 1'b1;
        repeat (4) @(posedge clk);
        stall <= 1'b0;
        add_beat(32'h90, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
        // same write held, then released with the address kept
        req   <= '{haddr: 32'h90, hwrite: 1'b1, hsize: WORD, hburst: SINGLE, htrans: NONSEQ};
        stall <= 1'b1;
        repeat (3) @(posedge clk);
        stall <= 1'b0;
        add_beat(32'h90, 1'b1, WORD, SINGLE, NONSEQ, rand_bits(32), 1'b0);
        add_beat(32'h90, 1'b0, WORD, SINGLE, NONSEQ, '0, 1'b0);
        run_and_check();
    endtask

    initial begin
        req    = idle_req;
        hwdata = '0;
        stall  = 1'b0;
        rstn   = 1'b0;
        n_x    = 0;
        repeat (5) @(posedge clk);
        rstn <= 1'b1;
        // idle slave after reset
        @(negedge clk);
        check_value("hreadyout after reset", rsp.hreadyout, 1'b1);
        check_value("hresp after reset", rsp.hresp, 1'b0);
        @(posedge clk);
        fill_memory();
        single_transfers();
        incr_bursts();
        wrap4_burst();
        read_after_write();
        error_responses();
        back_pressure();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
src/ahb_pkg.sv
src/ahb_burst_tracker.sv
src/ahb_slave_ctrl.sv
src/sram_bank.sv
src/ahb_mem_slave.sv
tb/tb_ahb_mem_slave.sv
